//--- hdl/sound_pkg.sv
// shared types and constants; offsets assume the 220h base, samples are signed 16-bit only
`default_nettype none

package sound_pkg;

    // ------------------------------
    // types
    typedef logic [15:0] sample_t;      // two's complement audio
    typedef logic [7:0]  byte_t;        // isa port data
    typedef logic [3:0]  io_addr_t;     // offset inside 220h-22fh
    typedef logic [8:0]  mgmt_addr_t;
    typedef logic [31:0] mgmt_data_t;

    typedef enum logic [1:0] {
        mix_idle,                       // waiting for fm tick
        mix_load_1,                     // dsp + fm clamp
        mix_load_2,                     // + speaker clamp
        mix_write                       // new_sample high
    } mix_state_t;

    typedef enum logic {
        dsp_cmd,                        // next write is a command byte
        dsp_dac_data                    // next write is a direct dac sample
    } dsp_state_t;

    // ------------------------------
    // 220h port offsets
    localparam io_addr_t io_dsp_reset = 4'h6;
    localparam io_addr_t io_dsp_read  = 4'hA;
    localparam io_addr_t io_dsp_write = 4'hC;
    localparam io_addr_t io_dsp_avail = 4'hE;
    localparam io_addr_t io_fm_index  = 4'h8;
    localparam io_addr_t io_fm_data   = 4'h9;

    // dsp commands
    localparam byte_t cmd_direct_dac  = 8'h10;
    localparam byte_t cmd_speaker_on  = 8'hD1;
    localparam byte_t cmd_speaker_off = 8'hD3;
    localparam byte_t dsp_reset_reply = 8'hAA;   // read back after reset handshake

    // fm register indices
    localparam byte_t fm_reg_amp  = 8'h01;   // 8-bit amplitude
    localparam byte_t fm_reg_half = 8'h02;   // half period in samples
    localparam byte_t fm_reg_ctrl = 8'h03;   // bit 0 tone enable

    // ------------------------------
    // management and mixer
    localparam mgmt_addr_t mgmt_sample_cycles    = 9'd257;  // [9:0] clocks per sample
    localparam logic [9:0] sample_cycles_default = 10'd8;
    localparam sample_t    speaker_low           = 16'd16384;
    localparam sample_t    speaker_high          = 16'd49152;   // negative as signed
    localparam sample_t    sample_max            = 16'd32767;
    localparam sample_t    sample_min            = 16'd32768;

endpackage

`default_nettype wire

//--- hdl/sound_dsp.sv
// dsp subset: reset handshake, direct dac 10h and speaker d1h/d3h only; no dma, no irq, never busy
`timescale 1ns/10ps
`default_nettype none

module sound_dsp (
    input  wire                      clk,
    input  wire                      rst_n,

    // 220h-22fh slave
    input  wire sound_pkg::io_addr_t io_address,
    input  wire                      io_read,
    input  wire                      io_write,
    input  wire sound_pkg::byte_t    io_writedata,
    output sound_pkg::byte_t         dsp_readdata,

    // to mixer
    output logic                     dac_disabled,
    output logic                     dac_strobe,     // one cycle per dac byte
    output sound_pkg::byte_t         dac_value       // unsigned
);

    import sound_pkg::*;

    // ------------------------------
    // decode
    logic       wr_reset;
    logic       wr_cmd;
    logic       rd_data;
    logic       reset_armed;    // saw a 1 at offset 6
    logic       reset_done;
    logic       avail;          // read latch holds unread byte
    byte_t      read_latch;
    dsp_state_t state;

    assign wr_reset = io_write && io_address == io_dsp_reset;
    assign wr_cmd   = io_write && io_address == io_dsp_write;
    assign rd_data  = io_read  && io_address == io_dsp_read;

    // 1 then 0 to the reset port completes the handshake
    assign reset_done = wr_reset && reset_armed && !io_writedata[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reset_armed <= 1'b0;
        end else if (wr_reset) begin
            reset_armed <= io_writedata[0];     // follows the reset bit
        end
    end

    // ------------------------------
    // read latch and avail flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_latch <= 8'h00;
            avail      <= 1'b0;
        end else if (reset_done) begin
            read_latch <= dsp_reset_reply;
            avail      <= 1'b1;
        end else if (rd_data) begin
            avail      <= 1'b0;                 // consumed by the host
        end
    end

    // ------------------------------
    // command decoder
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= dsp_cmd;
            dac_disabled <= 1'b1;
            dac_strobe   <= 1'b0;
        end else begin
            dac_strobe <= 1'b0;                 // pulse by default
            if (reset_done) begin
                state        <= dsp_cmd;        // abort pending command
                dac_disabled <= 1'b1;           // speaker off after reset
            end else if (wr_cmd) begin
                case (state)
                    dsp_cmd: begin
                        case (io_writedata)
                            cmd_direct_dac:  state        <= dsp_dac_data;
                            cmd_speaker_on:  dac_disabled <= 1'b0;
                            cmd_speaker_off: dac_disabled <= 1'b1;
                            default:         state        <= dsp_cmd;   // unknown, ignored
                        endcase
                    end
                    dsp_dac_data: begin
                        state      <= dsp_cmd;
                        dac_strobe <= 1'b1;     // sample goes out next cycle
                    end
                    default: begin
                        state <= dsp_cmd;
                    end
                endcase
            end
        end
    end

    // dac byte, valid with dac_strobe
    always_ff @(posedge clk) begin
        if (wr_cmd && state == dsp_dac_data) begin
            dac_value <= io_writedata;
        end
    end

    // ------------------------------
    // read data mux
    always_comb begin
        case (io_address)
            io_dsp_read:  dsp_readdata = read_latch;
            io_dsp_avail: dsp_readdata = {avail, 7'd0};    // bit 7 data ready
            io_dsp_write: dsp_readdata = 8'h00;            // never busy
            default:      dsp_readdata = 8'hFF;            // unmapped offsets read high
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/sound_fm_tone.sv
// fm stand-in: one square-wave tone, no opl2 operators or timers; fm port wins a same-cycle write
`timescale 1ns/10ps
`default_nettype none

module sound_fm_tone (
    input  wire                        clk,
    input  wire                        rst_n,

    // 220h-22fh slave, offsets 8 and 9
    input  wire sound_pkg::io_addr_t   io_address,
    input  wire                        io_read,
    input  wire                        io_write,
    input  wire sound_pkg::byte_t      io_writedata,
    output sound_pkg::byte_t           sb_readdata,

    // 388h-389h slave
    input  wire                        fm_address,
    input  wire                        fm_read,
    input  wire                        fm_write,
    input  wire sound_pkg::byte_t      fm_writedata,
    output sound_pkg::byte_t           fm_readdata,

    // management, only entry 257 is decoded
    input  wire sound_pkg::mgmt_addr_t mgmt_address,
    input  wire                        mgmt_write,
    input  wire sound_pkg::mgmt_data_t mgmt_writedata,

    // to mixer
    output logic                       fm_strobe,    // one per sample period
    output sound_pkg::sample_t         fm_value
);

    import sound_pkg::*;

    // ------------------------------
    // register file
    byte_t      index;
    byte_t      amp;
    byte_t      half;
    byte_t      ctrl;
    logic [9:0] sample_cycles;      // clocks per sample
    logic       wr_index;
    logic       wr_data;
    byte_t      wr_byte;

    assign wr_index = (io_write && io_address == io_fm_index) || (fm_write && !fm_address);
    assign wr_data  = (io_write && io_address == io_fm_data)  || (fm_write &&  fm_address);
    assign wr_byte  = fm_write ? fm_writedata : io_writedata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index <= 8'h00;
            amp   <= 8'h00;
            half  <= 8'h00;
            ctrl  <= 8'h00;         // tone off
        end else if (wr_index) begin
            index <= wr_byte;
        end else if (wr_data) begin
            case (index)
                fm_reg_amp:  amp  <= wr_byte;
                fm_reg_half: half <= wr_byte;
                fm_reg_ctrl: ctrl <= wr_byte;
                default:     index <= index;    // other opl2 regs not stored
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_cycles <= sample_cycles_default;
        end else if (mgmt_write && mgmt_address == mgmt_sample_cycles) begin
            sample_cycles <= mgmt_writedata[9:0];
        end
    end

    // ------------------------------
    // sample tick
    logic [9:0] cycle_cnt;
    logic       tick_due;

    // 0 and 1 both give a tick every clock
    assign tick_due = {1'b0, cycle_cnt} + 11'd1 >= {1'b0, sample_cycles};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= 10'd0;
            fm_strobe <= 1'b0;
        end else begin
            fm_strobe <= tick_due;
            cycle_cnt <= tick_due ? 10'd0 : cycle_cnt + 10'd1;
        end
    end

    // ------------------------------
    // square wave
    logic    tone_on;
    logic    polarity;          // 1 while in the negative half
    byte_t   half_cnt;          // ticks seen in this half
    logic    half_done;
    sample_t tone_mag;

    assign tone_on   = ctrl[0];
    assign half_done = {1'b0, half_cnt} + 9'd1 >= {1'b0, half};
    assign tone_mag  = {1'b0, amp, 7'd0};          // amp * 128

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            polarity <= 1'b0;
            half_cnt <= 8'h00;
        end else if (!tone_on) begin
            polarity <= 1'b0;       // restart on positive half
            half_cnt <= 8'h00;
        end else if (fm_strobe) begin
            if (half_done) begin
                polarity <= ~polarity;
                half_cnt <= 8'h00;
            end else begin
                half_cnt <= half_cnt + 8'd1;
            end
        end
    end

    // mixer latches this on fm_strobe, before the flip lands
    assign fm_value = !tone_on ? sample_t'(0) : (polarity ? -tone_mag : tone_mag);

    // ------------------------------
    // reads return the index
    assign sb_readdata = (io_read && (io_address == io_fm_index || io_address == io_fm_data))
                         ? index : 8'h00;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fm_readdata <= 8'h00;
        end else if (fm_read) begin
            fm_readdata <= index;   // both 388h and 389h
        end
    end

endmodule

`default_nettype wire

//--- hdl/sound_mixer.sv
// three-source mixer paced by fm_strobe; a tick arriving while busy is lost, no back-pressure
`timescale 1ns/10ps
`default_nettype none

module sound_mixer (
    input  wire                     clk,
    input  wire                     rst_n,

    // pc speaker
    input  wire                     speaker_enable,
    input  wire                     speaker_out,

    // dsp source
    input  wire                     dac_disabled,
    input  wire                     dac_strobe,
    input  wire sound_pkg::byte_t   dac_value,      // unsigned

    // fm source
    input  wire                     fm_strobe,
    input  wire sound_pkg::sample_t fm_value,       // signed

    // output
    output logic                    new_sample,
    output sound_pkg::sample_t      sample
);

    import sound_pkg::*;

    // signed add clamped to the 16-bit range
    function automatic sample_t sat_add(sample_t a, sample_t b);
        sample_t sum;
        sum = a + b;
        if (!a[15] && !b[15] && sum[15]) begin
            return sample_max;      // positive overflow
        end
        if (a[15] && b[15] && !sum[15]) begin
            return sample_min;      // negative overflow
        end
        return sum;
    endfunction

    // ------------------------------
    // source registers
    mix_state_t state;
    sample_t    speaker_value;
    sample_t    sample_dsp;
    sample_t    sample_fm;
    sample_t    sum_1_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            speaker_value <= 16'd0;
        end else if (speaker_enable) begin
            speaker_value <= speaker_out ? speaker_high : speaker_low;
        end else begin
            speaker_value <= 16'd0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_dsp <= 16'd0;
        end else if (dac_disabled) begin
            sample_dsp <= 16'd0;                                // muted
        end else if (dac_strobe) begin
            sample_dsp <= {dac_value, 8'd0} - 16'd32768;        // unsigned to signed
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_fm <= 16'd0;
        end else if (state == mix_idle && fm_strobe) begin
            sample_fm <= fm_value;                              // only accepted ticks
        end
    end

    // ------------------------------
    // two-stage clamp and output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= mix_idle;
            sum_1_q <= 16'd0;
            sample  <= 16'd0;
        end else begin
            case (state)
                mix_idle: begin
                    if (fm_strobe) begin
                        state <= mix_load_1;
                    end
                end
                mix_load_1: begin
                    sum_1_q <= sat_add(sample_dsp, sample_fm);
                    state   <= mix_load_2;
                end
                mix_load_2: begin
                    sample <= sat_add(sum_1_q, speaker_value);
                    state  <= mix_write;
                end
                default: begin
                    state <= mix_idle;                          // write lasts one cycle
                end
            endcase
        end
    end

    assign new_sample = state == mix_write;

endmodule

`default_nettype wire

//--- hdl/sound.sv
// sound card top: dsp, fm tone and mixer; no dma or irq, mgmt entries other than 257 are ignored
`timescale 1ns/10ps
`default_nettype none

module sound (
    input  wire                        clk,
    input  wire                        rst_n,

    // 220h-22fh slave
    input  wire sound_pkg::io_addr_t   io_address,
    input  wire                        io_read,
    output sound_pkg::byte_t           io_readdata,
    input  wire                        io_write,
    input  wire sound_pkg::byte_t      io_writedata,

    // 388h-389h slave
    input  wire                        fm_address,
    input  wire                        fm_read,
    output sound_pkg::byte_t           fm_readdata,
    input  wire                        fm_write,
    input  wire sound_pkg::byte_t      fm_writedata,

    // pc speaker
    input  wire                        speaker_enable,
    input  wire                        speaker_out,

    // management
    input  wire sound_pkg::mgmt_addr_t mgmt_address,
    input  wire                        mgmt_write,
    input  wire sound_pkg::mgmt_data_t mgmt_writedata,

    // audio out
    output logic                       new_sample,
    output sound_pkg::sample_t         sample
);

    import sound_pkg::*;

    byte_t   dsp_readdata;
    byte_t   sb_readdata;
    logic    dac_disabled;
    logic    dac_strobe;
    byte_t   dac_value;
    logic    fm_strobe;
    sample_t fm_value;

    // ------------------------------
    sound_dsp u_dsp (
        .clk          (clk),
        .rst_n        (rst_n),
        .io_address   (io_address),
        .io_read      (io_read),
        .io_write     (io_write),
        .io_writedata (io_writedata),
        .dsp_readdata (dsp_readdata),
        .dac_disabled (dac_disabled),
        .dac_strobe   (dac_strobe),
        .dac_value    (dac_value)
    );

    sound_fm_tone u_fm (
        .clk            (clk),
        .rst_n          (rst_n),
        .io_address     (io_address),
        .io_read        (io_read),
        .io_write       (io_write),
        .io_writedata   (io_writedata),
        .sb_readdata    (sb_readdata),
        .fm_address     (fm_address),
        .fm_read        (fm_read),
        .fm_write       (fm_write),
        .fm_writedata   (fm_writedata),
        .fm_readdata    (fm_readdata),
        .mgmt_address   (mgmt_address),
        .mgmt_write     (mgmt_write),
        .mgmt_writedata (mgmt_writedata),
        .fm_strobe      (fm_strobe),
        .fm_value       (fm_value)
    );

    sound_mixer u_mixer (
        .clk            (clk),
        .rst_n          (rst_n),
        .speaker_enable (speaker_enable),
        .speaker_out    (speaker_out),
        .dac_disabled   (dac_disabled),
        .dac_strobe     (dac_strobe),
        .dac_value      (dac_value),
        .fm_strobe      (fm_strobe),
        .fm_value       (fm_value),
        .new_sample     (new_sample),
        .sample         (sample)
    );

    // ------------------------------
    // registered 220h read mux, held between reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            io_readdata <= 8'h00;
        end else if (io_read) begin
            io_readdata <= (io_address == io_fm_index || io_address == io_fm_data)
                           ? sb_readdata : dsp_readdata;
        end
    end

endmodule

`default_nettype wire

//--- tests/sound_properties.sv
// assertions bound into the sound top; checks mixer pacing and the dsp dac strobe only
`timescale 1ns/10ps
`default_nettype none

module sound_properties (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          new_sample,
    input wire                          fm_strobe,
    input wire sound_pkg::mix_state_t   mix_state,
    input wire                          dac_strobe,
    input wire                          io_write,
    input wire sound_pkg::io_addr_t     io_address,
    input wire sound_pkg::dsp_state_t   dsp_state
);

    import sound_pkg::*;

    // ------------------------------
    // mixer
    new_sample_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        new_sample |=> !new_sample)
        else $error("new_sample held longer than one cycle");

    // accepted tick, then load_1, load_2, write
    new_sample_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (mix_state == mix_idle && fm_strobe) |-> ##3 new_sample)
        else $error("new_sample late after fm tick");

    // dsp strobe only after a data byte write
    dac_strobe_source: assert property (@(posedge clk) disable iff (!rst_n)
        dac_strobe |-> $past(io_write && io_address == io_dsp_write
                             && dsp_state == dsp_dac_data))
        else $error("dac_strobe without a dac data write");

endmodule

bind sound sound_properties props (
    .clk        (clk),
    .rst_n      (rst_n),
    .new_sample (new_sample),
    .fm_strobe  (fm_strobe),
    .mix_state  (u_mixer.state),
    .dac_strobe (dac_strobe),
    .io_write   (io_write),
    .io_address (io_address),
    .dsp_state  (u_dsp.state)
);

`default_nettype wire

//--- tests/sound_tb.sv
// testbench for the sound top; runs from the project root, reads tests/sound_stim.txt, mgmt 257 only
`timescale 1ns/10ps
`default_nettype none

module sound_tb;

    import sound_pkg::*;

    logic       clk;
    logic       rst_n;
    io_addr_t   io_address;
    logic       io_read;
    byte_t      io_readdata;
    logic       io_write;
    byte_t      io_writedata;
    logic       fm_address;
    logic       fm_read;
    byte_t      fm_readdata;
    logic       fm_write;
    byte_t      fm_writedata;
    logic       speaker_enable;
    logic       speaker_out;
    mgmt_addr_t mgmt_address;
    logic       mgmt_write;
    mgmt_data_t mgmt_writedata;
    logic       new_sample;
    sample_t    sample;

    sound dut (.*);

    // ------------------------------
    // 20 ns clock
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // stim records
    string q_name[$];
    string q_op[$];
    int    q_a[$];
    int    q_b[$];
    bit    loaded = 1'b0;

    // reference model state
    int m_index;
    int m_amp;
    int m_half;
    int m_ctrl;
    int m_dac_on;
    int m_dac_wait;
    int m_dsp;
    int m_armed;
    int m_spk;
    int m_cycles;
    int phase;
    logic [31:0] rng = 32'd83;

    int    errs;        // errors in current test
    int    n_pass;
    int    n_fail;
    string cur_test;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int clamp16(int v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    // expected mixer output for tone sample number ph
    function automatic int model_sample(int ph);
        int fm;
        int h;
        h  = (m_half < 1) ? 1 : m_half;      // half 0 flips every tick
        fm = 0;
        if (m_ctrl % 2 == 1) begin
            fm = ((ph / h) % 2 == 1) ? -(m_amp * 128) : m_amp * 128;
        end
        return clamp16(clamp16(m_dsp + fm) + m_spk);
    endfunction

    task automatic check(string name, int expected, int actual);
        if (expected !== actual) begin
            $display("error: test %s expected %0d actual %0d", name, expected, actual);
            errs++;
        end
    endtask

    // ------------------------------
    // model updates
    task automatic model_fm_write(int is_data, int d);
        if (is_data == 0) begin
            m_index = d;
        end else if (m_index == 1) begin
            m_amp = d;
        end else if (m_index == 2) begin
            m_half = d;
        end else if (m_index == 3) begin
            m_ctrl = d;
        end
    endtask

    task automatic model_io_write(int a, int d);
        if (a == 6) begin
            if (m_armed == 1 && d % 2 == 0) begin
                m_dac_on   = 0;             // handshake mutes the dac
                m_dac_wait = 0;
                m_dsp      = 0;
            end
            m_armed = d % 2;
        end else if (a == 12) begin
            if (m_dac_wait == 1) begin
                m_dac_wait = 0;
                if (m_dac_on == 1) m_dsp = d * 256 - 32768;
            end else if (d == 'h10) begin
                m_dac_wait = 1;
            end else if (d == 'hD1) begin
                m_dac_on = 1;
            end else if (d == 'hD3) begin
                m_dac_on = 0;
                m_dsp    = 0;
            end
        end else if (a == 8 || a == 9) begin
            model_fm_write(a - 8, d);
        end
    endtask

    // ------------------------------
    // bus tasks drive inputs on the falling edge
    task automatic io_wr(int a, int d);
        @(negedge clk);
        io_address   = io_addr_t'(a);
        io_writedata = byte_t'(d);
        io_write     = 1'b1;
        @(negedge clk);
        io_write     = 1'b0;
        model_io_write(a, d);
    endtask

    task automatic io_rd(int a, output int d);
        @(negedge clk);
        io_address = io_addr_t'(a);
        io_read    = 1'b1;
        @(negedge clk);
        io_read    = 1'b0;
        d = int'(io_readdata);           // registered one cycle after the read
    endtask

    task automatic fm_wr(int a, int d);
        @(negedge clk);
        fm_address   = a[0];
        fm_writedata = byte_t'(d);
        fm_write     = 1'b1;
        @(negedge clk);
        fm_write     = 1'b0;
        model_fm_write(a, d);
    endtask

    task automatic fm_rd(int a, output int d);
        @(negedge clk);
        fm_address = a[0];
        fm_read    = 1'b1;
        @(negedge clk);
        fm_read    = 1'b0;
        d = int'(fm_readdata);
    endtask

    task automatic mgmt_wr(int a, int d);
        @(negedge clk);
        mgmt_address   = mgmt_addr_t'(a);
        mgmt_writedata = mgmt_data_t'(d);
        mgmt_write     = 1'b1;
        @(negedge clk);
        mgmt_write     = 1'b0;
        if (a == 257) m_cycles = d % 1024;
    endtask

    // next new_sample pulse; sample is stable at the falling edge
    task automatic wait_sample(output int v, output int cycles);
        cycles = 0;
        v      = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!new_sample && cycles < 2000);
        if (!new_sample) begin
            $display("test %s: no new_sample pulse within 2000 cycles", cur_test);
            errs++;
        end else begin
            v = int'($signed(sample));
        end
    endtask

    task automatic close_test();
        $display("test %s: %s", cur_test, (errs == 0) ? "pass" : "fail");
        if (errs == 0) n_pass++;
        else n_fail++;
        errs = 0;
    endtask

    // ------------------------------
    // run one stim record
    task automatic run_record(string name, string op, int a, int b);
        int v;
        int cyc;
        int found;
        case (op)
            "iowr": io_wr(a, b);
            "fmwr": fm_wr(a, b);
            "mgmt": mgmt_wr(a, b);
            "iord": begin
                io_rd(a, v);
                check(name, b, v);
            end
            "fmrd": begin
                fm_rd(a, v);
                check(name, b, v);
            end
            "spk": begin
                @(negedge clk);
                speaker_enable = a[0];
                speaker_out    = b[0];
                m_spk = (a == 0) ? 0 : ((b == 0) ? 16384 : -16384);
            end
            "dacrand": begin
                rng = xorshift(rng);
                io_wr(12, int'(rng[7:0]));
            end
            "gap": begin
                wait_sample(v, cyc);            // align to a pulse
                wait_sample(v, cyc);
                check(name, m_cycles, cyc);
            end
            "sync": begin
                found = 0;
                for (int i = 0; i < 600 && found == 0; i++) begin
                    wait_sample(v, cyc);
                    if (v == model_sample(a)) found = 1;
                end
                if (found == 0) begin
                    $display("test %s: output never reached the expected tone phase", name);
                    errs++;
                end
                phase = a + 1;
            end
            "expect_sample": begin
                for (int i = 0; i < a; i++) begin
                    wait_sample(v, cyc);
                    check(name, model_sample(phase), v);
                    phase++;
                end
            end
            default: begin
                $display("test %s: unknown stim op %s", name, op);
                errs++;
            end
        endcase
    endtask

    // ------------------------------
    // main sequence
    initial begin
        int    fd;
        int    cnt;
        string line;
        string name;
        string op;
        int    a;
        int    b;

        rst_n          = 1'b0;
        io_address     = '0;
        io_read        = 1'b0;
        io_write       = 1'b0;
        io_writedata   = '0;
        fm_address     = 1'b0;
        fm_read        = 1'b0;
        fm_write       = 1'b0;
        fm_writedata   = '0;
        speaker_enable = 1'b0;
        speaker_out    = 1'b0;
        mgmt_address   = '0;
        mgmt_write     = 1'b0;
        mgmt_writedata = '0;
        m_index        = 0;
        m_amp          = 0;
        m_half         = 0;
        m_ctrl         = 0;
        m_dac_on       = 0;
        m_dac_wait     = 0;
        m_dsp          = 0;
        m_armed        = 0;
        m_spk          = 0;
        m_cycles       = 8;
        phase          = 0;
        errs           = 0;
        n_pass         = 0;
        n_fail         = 0;

        fd = $fopen("tests/sound_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/sound_stim.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                cnt = $fgets(line, fd);
                if (cnt > 0 && line.substr(0, 0) != "#") begin
                    cnt = $sscanf(line, "%s %s %h %h", name, op, a, b);
                    if (cnt == 4) begin
                        q_name.push_back(name);
                        q_op.push_back(op);
                        q_a.push_back(a);
                        q_b.push_back(b);
                    end
                end
            end
            $fclose(fd);
            loaded = 1'b1;

            repeat (4) @(posedge clk);          // reset for 4 cycles
            @(negedge clk);
            rst_n = 1'b1;

            cur_test = q_name[0];
            foreach (q_op[i]) begin
                if (q_name[i] != cur_test) begin
                    close_test();
                    cur_test = q_name[i];
                end
                run_record(q_name[i], q_op[i], q_a[i], q_b[i]);
            end
            close_test();

            $display("tests passed %0d failed %0d", n_pass, n_fail);
            if (n_fail == 0 && n_pass > 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // watchdog allows 40 us per record
    initial begin
        wait (loaded);
        #(q_op.size() * 40000);
        $display("watchdog: run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/sound_stim.txt
# columns: test op a b, a and b in hex; iowr fmwr mgmt take address and data
# iord fmrd take address and expected byte; spk enable level; sync tone phase; expect_sample count
dsp_reset iowr 6 1
dsp_reset iowr 6 0
dsp_reset iord E 80
dsp_reset iord A AA
dsp_reset iord E 0
fm_regs fmwr 0 3
fm_regs fmrd 0 3
fm_regs iord 8 3
rate mgmt 101 14
rate gap 0 0
direct_dac iowr C D1
direct_dac iowr C 10
direct_dac dacrand 0 0
direct_dac sync 0 0
direct_dac expect_sample 2 0
tone iowr C D3
tone spk 0 0
tone fmwr 0 1
tone fmwr 1 40
tone fmwr 0 2
tone fmwr 1 3
tone fmwr 0 3
tone fmwr 1 1
tone sync 0 0
tone expect_sample 5 0
sat_high fmwr 1 0
sat_high fmwr 0 1
sat_high fmwr 1 FF
sat_high fmwr 0 2
sat_high fmwr 1 10
sat_high iowr C D1
sat_high iowr C 10
sat_high iowr C FF
sat_high spk 1 0
sat_high fmwr 0 3
sat_high fmwr 1 1
sat_high sync 0 0
sat_high expect_sample 1 0
sat_low iowr C 10
sat_low iowr C 0
sat_low spk 1 1
sat_low sync 10 0
sat_low expect_sample 1 0

//--- list.f
hdl/sound_pkg.sv
hdl/sound_dsp.sv
hdl/sound_fm_tone.sv
hdl/sound_mixer.sv
hdl/sound.sv
tests/sound_properties.sv
tests/sound_tb.sv

//--- run.sh
#!/bin/sh
# build and run the sound testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module sound_tb -f list.f -o sound_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sound_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
